/* hdl/eth_sw_pkg.sv */
package eth_sw_pkg;

  //////////////////////////////////////////////////////////////////////
  // ingress byte buffer
  //////////////////////////////////////////////////////////////////////

  // one capture worth of bytes per port
  localparam int buf_aw    = 10;
  localparam int buf_depth = 1 << buf_aw;

  //////////////////////////////////////////////////////////////////////
  // descriptor queue
  //////////////////////////////////////////////////////////////////////

  // eight complete frames per port
  localparam int desc_aw    = 3;
  localparam int desc_depth = 1 << desc_aw;

  //////////////////////////////////////////////////////////////////////
  // frame length
  //////////////////////////////////////////////////////////////////////

  // must hold max_frame itself, not just max_frame - 1
  localparam int len_w     = 11;
  localparam int max_frame = 1024;

endpackage

/* hdl/frame_buf_if.sv */
`timescale 1ns/100ps

interface frame_buf_if;

  // head descriptor of the ingress queue
  logic                           pend;
  logic [eth_sw_pkg::len_w-1:0]   len;

  // byte read, d follows rd by one cycle
  logic                           rd;
  logic [7:0]                     d;

  // pops the head frame, comes with its last rd
  logic                           done;

  modport ingress (
    output pend,
    output len,
    output d,
    input  rd,
    input  done
  );

  modport arbiter (
    input  pend,
    input  len,
    input  d,
    output rd,
    output done
  );

endinterface

/* hdl/frame_ingress.sv */
`timescale 1ns/100ps

module frame_ingress (
  input  logic         clk,
  input  logic         rst,
  input  logic         rx_v,
  input  logic [7:0]   rx_d,
  output logic         drop,
  frame_buf_if.ingress bus
);

  logic [7:0]                        mem [eth_sw_pkg::buf_depth];
  logic [eth_sw_pkg::len_w-1:0]      desc_mem [eth_sw_pkg::desc_depth];

  // write side
  logic [eth_sw_pkg::buf_aw-1:0]     wr_ptr;
  logic [eth_sw_pkg::buf_aw-1:0]     frm_start;
  logic [eth_sw_pkg::len_w-1:0]      frm_len;
  logic                              in_frame;
  logic                              frm_ovf;

  // read side
  logic [eth_sw_pkg::buf_aw-1:0]     rd_ptr;
  logic [eth_sw_pkg::len_w-1:0]      used;

  // descriptor queue
  logic [eth_sw_pkg::desc_aw-1:0]    desc_wp;
  logic [eth_sw_pkg::desc_aw-1:0]    desc_rp;
  logic [eth_sw_pkg::desc_aw:0]      desc_cnt;

  logic [eth_sw_pkg::len_w:0]        fill;
  logic [eth_sw_pkg::len_w-1:0]      add_len;
  logic [eth_sw_pkg::len_w-1:0]      sub_len;
  logic                              room;
  logic                              wr_en;
  logic                              frm_end;
  logic                              desc_full;
  logic                              commit;
  logic                              reject;

  //////////////////////////////////////////////////////////////////////
  // admission
  //////////////////////////////////////////////////////////////////////

  // committed bytes plus the frame so far, shrinks as frames are freed
  assign fill = {1'b0, used} + {1'b0, frm_len};

  assign room = (fill < eth_sw_pkg::buf_depth) &&
                (frm_len < eth_sw_pkg::max_frame);

  // once a frame overflows, nothing more of it is stored
  assign wr_en     = rx_v && !frm_ovf && room;

  // first idle cycle after a run of valid bytes
  assign frm_end   = in_frame && !rx_v;
  assign desc_full = desc_cnt == eth_sw_pkg::desc_depth;
  assign commit    = frm_end && !frm_ovf && !desc_full;
  assign reject    = frm_end && !commit;

  assign add_len = commit   ? frm_len : '0;
  assign sub_len = bus.done ? bus.len : '0;

  //////////////////////////////////////////////////////////////////////
  // pointers and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame  <= 1'b0;
      frm_ovf   <= 1'b0;
      frm_len   <= '0;
      wr_ptr    <= '0;
      frm_start <= '0;
      rd_ptr    <= '0;
      used      <= '0;
      desc_wp   <= '0;
      desc_rp   <= '0;
      desc_cnt  <= '0;
      drop      <= 1'b0;
    end else begin
      in_frame <= rx_v;
      drop     <= reject;

      if (wr_en) begin
        wr_ptr  <= wr_ptr + 1'b1;
        frm_len <= frm_len + 1'b1;
      end
      if (rx_v && !wr_en) begin
        frm_ovf <= 1'b1;
      end

      if (frm_end) begin
        frm_len <= '0;
        frm_ovf <= 1'b0;
      end
      if (commit) begin
        desc_wp   <= desc_wp + 1'b1;
        frm_start <= wr_ptr;
      end
      // discard everything written for this frame
      if (reject) begin
        wr_ptr <= frm_start;
      end

      if (bus.rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (bus.done) begin
        desc_rp <= desc_rp + 1'b1;
      end

      case ({commit, bus.done})
        2'b10:   desc_cnt <= desc_cnt + 1'b1;
        2'b01:   desc_cnt <= desc_cnt - 1'b1;
        default: desc_cnt <= desc_cnt;
      endcase

      used <= used + add_len - sub_len;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= rx_d;
    end
    if (commit) begin
      desc_mem[desc_wp] <= frm_len;
    end
    if (bus.rd) begin
      bus.d <= mem[rd_ptr];
    end
  end

  assign bus.pend = desc_cnt != '0;
  assign bus.len  = desc_mem[desc_rp];

endmodule

/* hdl/frame_arbiter.sv */
`timescale 1ns/100ps

module frame_arbiter (
  input  logic         clk,
  input  logic         rst,
  input  logic         rdy,
  frame_buf_if.arbiter p0,
  frame_buf_if.arbiter p1,
  output logic         tx_v,
  output logic [7:0]   tx_d,
  output logic         tx_eof
);

  // frame in progress
  logic                           busy;
  logic                           last_port;
  logic [eth_sw_pkg::len_w-1:0]   rem;

  logic                           pick;
  logic [eth_sw_pkg::len_w-1:0]   pick_len;
  logic                           start;
  logic                           port;
  logic                           rd;
  logic                           rd_last;

  // read return and skid
  logic                           rd_q;
  logic                           eof_q;
  logic [7:0]                     rd_byte;
  logic                           skid_v;
  logic                           skid_eof;
  logic [7:0]                     skid_d;
  logic                           skid_load;

  //////////////////////////////////////////////////////////////////////
  // selection
  //////////////////////////////////////////////////////////////////////

  // other port first
  always_comb begin
    if (last_port) begin
      pick = !p0.pend;
    end else begin
      pick = p1.pend;
    end
  end

  assign pick_len = pick ? p1.len : p0.len;

  // previous frame leaves the read path first so tx_v gets its gap
  assign start = !busy && !rd_q && !skid_v && rdy && (p0.pend || p1.pend);

  assign port    = start ? pick : last_port;
  assign rd      = start || (busy && rdy);
  assign rd_last = start ? (pick_len == 1) : (rem == 1);

  assign p0.rd   = rd && !port;
  assign p1.rd   = rd && port;
  assign p0.done = rd && rd_last && !port;
  assign p1.done = rd && rd_last && port;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      last_port <= 1'b1;
      rem       <= '0;
    end else if (start) begin
      busy      <= !rd_last;
      last_port <= pick;
      rem       <= pick_len - 1'b1;
    end else if (busy && rdy) begin
      busy <= !rd_last;
      rem  <= rem - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register with skid
  //////////////////////////////////////////////////////////////////////

  assign rd_byte = last_port ? p1.d : p0.d;

  // byte returning while rdy is low, or behind a held byte
  assign skid_load = rd_q && (!rdy || skid_v);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q     <= 1'b0;
      eof_q    <= 1'b0;
      skid_v   <= 1'b0;
      skid_eof <= 1'b0;
      tx_v     <= 1'b0;
      tx_eof   <= 1'b0;
    end else begin
      rd_q  <= rd;
      eof_q <= rd && rd_last;

      tx_v   <= rdy && (skid_v || rd_q);
      tx_eof <= rdy && (skid_v ? skid_eof : (rd_q && eof_q));

      if (rdy) begin
        skid_v <= skid_v && rd_q;
      end else begin
        skid_v <= skid_v || rd_q;
      end
      if (skid_load) begin
        skid_eof <= eof_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdy) begin
      tx_d <= skid_v ? skid_d : rd_byte;
    end
    if (skid_load) begin
      skid_d <= rd_byte;
    end
  end

endmodule

/* hdl/eth_switch.sv */
`timescale 1ns/100ps

module eth_switch (
  input  logic       clk,
  input  logic       rst,

  input  logic       rx_v_0,
  input  logic [7:0] rx_d_0,
  input  logic       rx_v_1,
  input  logic [7:0] rx_d_1,

  input  logic       rdy,

  output logic       tx_v,
  output logic [7:0] tx_d,
  output logic       tx_eof,

  output logic       drop_0,
  output logic       drop_1
);

  frame_buf_if bus_0 ();
  frame_buf_if bus_1 ();

  //////////////////////////////////////////////////////////////////////
  // ingress, one per port
  //////////////////////////////////////////////////////////////////////

  frame_ingress u_ing0 (
    .clk  (clk),
    .rst  (rst),
    .rx_v (rx_v_0),
    .rx_d (rx_d_0),
    .drop (drop_0),
    .bus  (bus_0.ingress)
  );

  frame_ingress u_ing1 (
    .clk  (clk),
    .rst  (rst),
    .rx_v (rx_v_1),
    .rx_d (rx_d_1),
    .drop (drop_1),
    .bus  (bus_1.ingress)
  );

  //////////////////////////////////////////////////////////////////////
  // merge onto the shared bus
  //////////////////////////////////////////////////////////////////////

  frame_arbiter u_arb (
    .clk    (clk),
    .rst    (rst),
    .rdy    (rdy),
    .p0     (bus_0.arbiter),
    .p1     (bus_1.arbiter),
    .tx_v   (tx_v),
    .tx_d   (tx_d),
    .tx_eof (tx_eof)
  );

endmodule

/* verification/tb_eth_switch.sv */
`timescale 1ns/100ps

module tb_eth_switch;

  localparam logic [15:0] seed = 16'd28340;
  localparam int idle_timeout  = 4000;
  localparam int nj            = 128;
  localparam int nb            = 4096;

  logic       clk    = 1'b0;
  logic       rst    = 1'b1;
  logic       rdy    = 1'b0;
  logic       rx_v_0 = 1'b0;
  logic [7:0] rx_d_0 = 8'h00;
  logic       rx_v_1 = 1'b0;
  logic [7:0] rx_d_1 = 8'h00;
  logic       tx_v;
  logic [7:0] tx_d;
  logic       tx_eof;
  logic       drop_0;
  logic       drop_1;

  // per port frame jobs, driver state, expected frames and drops
  int          job_len [2][nj];
  int          job_gap [2][nj];
  int          job_wr [2];
  int          job_rd [2];
  int          byte_left [2];
  int          gap_left [2];
  int          cur_gap [2];
  bit          cur_acc [2];
  logic [7:0]  exp_mem [2][nb];
  int          exp_wr [2];
  int          exp_rd [2];
  int          len_mem [2][nj];
  int          len_wr [2];
  int          len_rd [2];
  int          out_cnt [2];
  int          out_bytes [2];
  bit          drop_flag [2][nj];
  int          drop_wr [2];
  int          drop_rd [2];
  bit          end_seen [2];
  bit          prev_v [2];

  logic [7:0]  got [nb];
  int          got_n;
  int          low_run;
  bit          prev_eof;
  bit          mon_on;
  int          seg_frames;
  int          seg_repeat;
  int          seg_first;
  int          seg_last;
  int          frames_rx;
  logic [15:0] pay_lfsr;
  logic [15:0] rdy_lfsr;

  eth_switch u_dut (
    .clk    (clk),
    .rst    (rst),
    .rx_v_0 (rx_v_0),
    .rx_d_0 (rx_d_0),
    .rx_v_1 (rx_v_1),
    .rx_d_1 (rx_d_1),
    .rdy    (rdy),
    .tx_v   (tx_v),
    .tx_d   (tx_d),
    .tx_eof (tx_eof),
    .drop_0 (drop_0),
    .drop_1 (drop_1)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(inout logic [15:0] st, input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[14:0], st[0]};
      st  = lfsr_step(st);
    end
  endtask

  task automatic fail_now();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // acceptance decided at frame start since nothing drains while rdy is low
  task automatic start_frame(input int p);
    int  len;
    bit  acc;
    len = job_len[p][job_rd[p]];
    acc = (out_bytes[p] + len <= eth_sw_pkg::buf_depth) &&
          (len <= eth_sw_pkg::max_frame) && (out_cnt[p] < (1 << eth_sw_pkg::desc_aw));
    cur_gap[p] = (job_gap[p][job_rd[p]] < 1) ? 1 : job_gap[p][job_rd[p]];
    job_rd[p]++;
    drop_flag[p][drop_wr[p]] = !acc;
    drop_wr[p]++;
    if (acc) begin
      len_mem[p][len_wr[p]] = len;
      len_wr[p]++;
      out_cnt[p]++;
      out_bytes[p] += len;
    end
    byte_left[p] = len;
    cur_acc[p]   = acc;
  endtask

  task automatic step_port(input int p, output logic v, output logic [7:0] d);
    logic [15:0] r;
    v = 1'b0;
    d = 8'h00;
    if (gap_left[p] > 0) begin
      gap_left[p]--;
    end else begin
      if (byte_left[p] == 0 && job_rd[p] < job_wr[p]) begin
        start_frame(p);
      end
      if (byte_left[p] > 0) begin
        take_bits(pay_lfsr, 8, r);
        v = 1'b1;
        d = r[7:0];
        if (cur_acc[p]) begin
          exp_mem[p][exp_wr[p]] = d;
          exp_wr[p]++;
        end
        byte_left[p]--;
        if (byte_left[p] == 0) begin
          gap_left[p] = cur_gap[p];
        end
      end
    end
  endtask

  always @(posedge clk) begin : drive
    logic       v;
    logic [7:0] d;
    #10;
    step_port(0, v, d);
    rx_v_0 = v;
    rx_d_0 = d;
    step_port(1, v, d);
    rx_v_1 = v;
    rx_d_1 = d;
  end

  //////////////////////////////////////////////////////////////////////
  // monitors and scoreboard
  //////////////////////////////////////////////////////////////////////

  // drop pulse lands two cycles after the last byte
  task automatic drop_watch(input int p, input logic v, input logic dr);
    bit exp;
    exp = 1'b0;
    if (end_seen[p]) begin
      exp = drop_flag[p][drop_rd[p]];
      drop_rd[p]++;
    end
    assert (dr === exp) else begin
      $display("error at %0d ns: drop_%0d got %b expected %b", $time, p, dr, exp);
      fail_now();
    end
    end_seen[p] = prev_v[p] && (v !== 1'b1);
    prev_v[p]   = (v === 1'b1);
  endtask

  function automatic int prefix_len(input int p);
    int n;
    if (out_cnt[p] == 0) begin
      return -1;
    end
    n = 0;
    while (n < got_n && n < len_mem[p][len_rd[p]] &&
           got[n] === exp_mem[p][exp_rd[p] + n]) begin
      n++;
    end
    return n;
  endfunction

  task automatic finish_frame();
    int m0;
    int m1;
    int p;
    int m;
    int len;
    m0 = prefix_len(0);
    m1 = prefix_len(1);
    assert (m0 >= 0 || m1 >= 0) else begin
      $display("output frame of %0d bytes arrived with no frame queued", got_n);
      fail_now();
    end
    p   = (m1 > m0) ? 1 : 0;
    m   = (p == 1) ? m1 : m0;
    len = len_mem[p][len_rd[p]];
    assert (m >= got_n || m >= len) else begin
      $display("error at %0d ns: tx_d byte %0d of port %0d frame got %02h expected %02h",
               $time, m, p, got[m], exp_mem[p][exp_rd[p] + m]);
      fail_now();
    end
    assert (got_n == len) else begin
      $display("error at %0d ns: tx frame length of port %0d got %0d expected %0d",
               $time, p, got_n, len);
      fail_now();
    end
    exp_rd[p] += len;
    len_rd[p]++;
    out_cnt[p]--;
    out_bytes[p] -= len;
    if (seg_frames == 0) begin
      seg_first = p;
    end else if (p == seg_last) begin
      seg_repeat++;
    end
    seg_last = p;
    seg_frames++;
    frames_rx++;
    got_n = 0;
  endtask

  always @(negedge clk) begin
    if (mon_on) begin
      drop_watch(0, rx_v_0, drop_0);
      drop_watch(1, rx_v_1, drop_1);
      assert (!(tx_v && low_run >= 2)) else begin
        $display("error at %0d ns: tx_v got 1 expected 0 with rdy low for %0d cycles",
                 $time, low_run);
        fail_now();
      end
      assert (!(prev_eof && tx_v)) else begin
        $display("error at %0d ns: tx_v got 1 expected 0 right after tx_eof", $time);
        fail_now();
      end
      assert (tx_eof === 1'b0 || tx_v === 1'b1) else begin
        $display("error at %0d ns: tx_eof got %b expected 0 without tx_v", $time, tx_eof);
        fail_now();
      end
      assert (tx_v === 1'b0 || out_cnt[0] + out_cnt[1] > 0) else begin
        $display("tx_v went high at %0d ns while no frame was queued", $time);
        fail_now();
      end
      if (tx_v === 1'b1) begin
        got[got_n] = tx_d;
        got_n++;
        if (tx_eof === 1'b1) begin
          finish_frame();
        end
      end
      prev_eof = (tx_eof === 1'b1);
      low_run  = rdy ? 0 : low_run + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // vector commands
  //////////////////////////////////////////////////////////////////////

  task automatic set_ready(input int level, input int cycles);
    logic [15:0] r;
    for (int i = 0; i < cycles; i++) begin
      if (level == 2) begin
        take_bits(rdy_lfsr, 1, r);
        rdy = r[0];
      end else begin
        rdy = (level != 0);
      end
      @(posedge clk);
      #10;
    end
  endtask

  function automatic bit drained();
    for (int p = 0; p < 2; p++) begin
      if (job_rd[p] != job_wr[p] || byte_left[p] != 0 || gap_left[p] != 0 ||
          out_cnt[p] != 0 || drop_rd[p] != drop_wr[p]) begin
        return 1'b0;
      end
    end
    return got_n == 0;
  endfunction

  task automatic wait_idle(input int order);
    int n;
    n = 0;
    while (!drained()) begin
      @(posedge clk);
      #10;
      n++;
      if (n > idle_timeout) begin
        $display("timed out after %0d cycles waiting for the switch to drain", idle_timeout);
        fail_now();
      end
    end
    if (order == 1) begin
      assert (seg_frames > 1 && seg_first == 0 && seg_repeat == 0) else begin
        $display("error at %0d ns: port order got first %0d with %0d repeats expected %s",
                 $time, seg_first, seg_repeat, "first 0 with 0 repeats");
        fail_now();
      end
    end
    seg_frames = 0;
    seg_repeat = 0;
  endtask

  initial begin : main
    int               fd;
    int               code;
    int               a;
    int               b;
    int               c;
    logic [7:0]       cmd;
    logic [8*128-1:0] line;
    pay_lfsr = seed;
    rdy_lfsr = seed;
    fd = $fopen("verification/switch_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/switch_vectors.txt");
      fail_now();
    end
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    assert ({tx_v, tx_eof, drop_0, drop_1} === 4'b0000) else begin
      $display("error at %0d ns: outputs after reset got %b expected 0000",
               $time, {tx_v, tx_eof, drop_0, drop_1});
      fail_now();
    end
    mon_on = 1'b1;
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": code = $fgets(line, fd);
        "F": begin
          code = $fscanf(fd, "%d %d %d", a, b, c);
          if (code != 3 || a < 0 || a > 1 || b < 1) begin
            $display("bad frame line in the vector file");
            fail_now();
          end
          job_len[a][job_wr[a]] = b;
          job_gap[a][job_wr[a]] = c;
          job_wr[a]++;
        end
        "R": begin
          code = $fscanf(fd, "%d %d", a, b);
          set_ready(a, b);
        end
        "I": begin
          code = $fscanf(fd, "%d", a);
          wait_idle(a);
        end
        default: begin
          $display("unknown command in the vector file");
          fail_now();
        end
      endcase
    end
    $fclose(fd);
    if (frames_rx > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("no frame ever left the switch");
      fail_now();
    end
  end

endmodule

/* verification/switch_vectors.txt */
# F port len gap : frame of len bytes on a port, then gap idle cycles
# R level cycles : rdy 0, 1 or 2 for random, held for the given cycles
# I order        : wait until drained, order 1 expects ports 0, 1, 0, 1, ...
R 1 4
F 0 64 2
I 0
F 1 1 1
I 0
# both ports at once
F 0 40 2
F 1 33 1
F 0 17 4
F 1 90 3
I 0
F 1 12 2
I 0
# round-robin behind rdy low
R 0 2
F 0 20 2
F 0 21 2
F 0 22 2
F 1 30 1
F 1 31 1
F 1 32 1
R 0 120
R 1 1
I 1
# random back-pressure
F 0 100 2
F 1 70 3
F 0 45 1
F 1 120 2
R 2 600
R 1 1
I 0
# port 0 past the byte and descriptor limits, drops on 200, 5, 14 and 15
R 0 2
F 0 300 2
F 0 300 2
F 0 300 2
F 0 200 2
F 0 20 2
F 0 20 2
F 0 20 2
F 0 20 2
F 0 30 2
F 0 5 2
F 0 14 2
F 0 15 2
R 0 1350
R 1 1
I 0

/* compile.f */
hdl/eth_sw_pkg.sv
hdl/frame_buf_if.sv
hdl/frame_ingress.sv
hdl/frame_arbiter.sv
hdl/eth_switch.sv
verification/tb_eth_switch.sv

/* Bender.yml */
package:
  name: eth_switch

sources:
  - hdl/eth_sw_pkg.sv
  - hdl/frame_buf_if.sv
  - hdl/frame_ingress.sv
  - hdl/frame_arbiter.sv
  - hdl/eth_switch.sv
  - target: simulation
    files:
      - verification/tb_eth_switch.sv
